//--- dv/apb_mem_model.sv
`timescale 1ns/1ps

module apb_mem_model
    import cache_mem_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    localparam int MEM_WORDS = 256;

    word_t      mem [MEM_WORDS];
    int         wait_left;
    integer     seed = 47;
    logic [7:0] idx;

    assign idx            = apb_req.paddr[9:2];
    // access phase completes once the wait states run out
    assign apb_rsp.pready = apb_req.psel && apb_req.penable && (wait_left == 0);
    assign apb_rsp.prdata = mem[idx];

    always @(posedge clk) begin
        if (!rstn) begin
            wait_left <= 0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (apb_req.psel && !apb_req.penable) begin
            // 0 to 3 wait states per transfer
            wait_left <= $random(seed) & 3;
        end else if (apb_req.psel && apb_req.penable) begin
            if (wait_left != 0) begin
                wait_left <= wait_left - 1;
            end else if (apb_req.pwrite) begin
                for (int b = 0; b < 4; b++) begin
                    if (apb_req.pstrb[b]) begin
                        mem[idx][8*b +: 8] <= apb_req.pwdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- dv/tb_cache_mem.sv
`timescale 1ns/1ps

module tb_cache_mem
    import cache_mem_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int MEM_WORDS      = 256;
    localparam int WORD_BITS      = $bits(word_t);
    localparam int NUM_DIRECTED   = 10;
    localparam int NUM_RANDOM     = 200;
    localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 40 + 500;

    logic        clk;
    logic        rstn;
    icache_req_e icache_req;
    addr_t       icache_addr;
    dcache_req_e dcache_req;
    addr_t       dcache_addr;
    word_t       dcache_wword;
    strb_t       dcache_wstrb;
    block_t      dcache_wblock;
    resp_e       response;
    word_t       rword;
    block_t      rblock;
    apb_req_t    apb_out;
    apb_rsp_t    apb_in;

    // reference memory follows every completed store
    word_t       model_mem [MEM_WORDS];
    resp_e       exp_order [$];
    logic        d_busy;
    logic        i_busy;
    dcache_req_e d_kind;
    addr_t       d_addr;
    word_t       d_wword;
    strb_t       d_wstrb;
    block_t      d_wblock;
    icache_req_e i_kind;
    addr_t       i_addr;
    integer      seed = 47;
    string       test_name;
    int          issued;
    int          answered;
    int          remaining;
    dcache_req_e dk;
    icache_req_e ik;
    block_t      blk;

    cache_mem_top u_dut (
        .clk           (clk),
        .rstn          (rstn),
        .icache_req    (icache_req),
        .icache_addr   (icache_addr),
        .dcache_req    (dcache_req),
        .dcache_addr   (dcache_addr),
        .dcache_wword  (dcache_wword),
        .dcache_wstrb  (dcache_wstrb),
        .dcache_wblock (dcache_wblock),
        .response      (response),
        .rword         (rword),
        .rblock        (rblock),
        .apb_out       (apb_out),
        .apb_in        (apb_in)
    );

    apb_mem_model u_mem (
        .clk     (clk),
        .rstn    (rstn),
        .apb_req (apb_out),
        .apb_rsp (apb_in)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // counts every response cycle, also the ones nobody waits for
    always @(negedge clk) begin
        if (rstn && (response != RESP_NONE)) begin
            answered++;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run ended with %0d requests still pending", exp_order.size());
        stop_with_failure();
    end

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic compare_block(input string what, input block_t exp, input block_t act);
        if (exp !== act) begin
            $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic compare_resp(input resp_e exp, input resp_e act);
        if (exp !== act) begin
            $display("error: %s response expected %s actual %s",
                     test_name, exp.name(), act.name());
            stop_with_failure();
        end
    endtask

    function automatic word_t model_word(input addr_t a);
        return model_mem[a[9:2]];
    endfunction

    // word i of a block lives at the aligned address plus 4*i
    function automatic block_t model_block(input addr_t a);
        block_t     b;
        logic [7:0] base;
        base = {a[9:4], 2'b00};
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            b[i*WORD_BITS +: WORD_BITS] = model_mem[base + i];
        end
        return b;
    endfunction

    task automatic model_store(input addr_t a, input word_t w, input strb_t s);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                model_mem[a[9:2]][8*b +: 8] = w[8*b +: 8];
            end
        end
    endtask

    function automatic addr_t rand_addr();
        return addr_t'($random(seed)) & addr_t'(32'h0000_03FF);
    endfunction

    function automatic block_t rand_block();
        block_t b;
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            b[i*WORD_BITS +: WORD_BITS] = $random(seed);
        end
        return b;
    endfunction

    function automatic dcache_req_e rand_dcache_kind();
        case ($random(seed) & 3)
            0:       return DCACHE_REQ_LOAD_WORD;
            1:       return DCACHE_REQ_LOAD_BLOCK;
            2:       return DCACHE_REQ_STORE_WORD;
            default: return DCACHE_REQ_STORE_BLOCK;
        endcase
    endfunction

    function automatic icache_req_e rand_icache_kind();
        return ($random(seed) & 1) ? ICACHE_REQ_BLOCK : ICACHE_REQ_WORD;
    endfunction

    // one-cycle request pulse on either or both sides
    // both in one cycle means dcache goes first
    task automatic send_requests(input dcache_req_e dkind, input addr_t da, input word_t dw,
                                 input strb_t ds, input block_t db,
                                 input icache_req_e ikind, input addr_t ia);
        @(posedge clk);
        #1;
        if (dkind != DCACHE_REQ_NONE) begin
            dcache_req    = dkind;
            dcache_addr   = da;
            dcache_wword  = dw;
            dcache_wstrb  = ds;
            dcache_wblock = db;
            d_kind        = dkind;
            d_addr        = da;
            d_wword       = dw;
            d_wstrb       = ds;
            d_wblock      = db;
            d_busy        = 1'b1;
            exp_order.push_back(RESP_DCACHE);
            issued++;
        end
        if (ikind != ICACHE_REQ_NONE) begin
            icache_req  = ikind;
            icache_addr = ia;
            i_kind      = ikind;
            i_addr      = ia;
            i_busy      = 1'b1;
            exp_order.push_back(RESP_ICACHE);
            issued++;
        end
        @(posedge clk);
        #1;
        dcache_req = DCACHE_REQ_NONE;
        icache_req = ICACHE_REQ_NONE;
    endtask

    task automatic check_dcache_result();
        addr_t base;
        base = {d_addr[31:4], 4'h0};
        case (d_kind)
            DCACHE_REQ_LOAD_WORD:  compare_word("dcache rword", model_word(d_addr), rword);
            DCACHE_REQ_LOAD_BLOCK: compare_block("dcache rblock", model_block(d_addr), rblock);
            DCACHE_REQ_STORE_WORD: model_store(d_addr, d_wword, d_wstrb);
            default: begin
                for (int i = 0; i < BLOCK_WORDS; i++) begin
                    model_store(base + 4 * i, d_wblock[i*WORD_BITS +: WORD_BITS], 4'hF);
                end
            end
        endcase
        d_busy = 1'b0;
    endtask

    task automatic check_icache_result();
        if (i_kind == ICACHE_REQ_BLOCK) begin
            compare_block("icache rblock", model_block(i_addr), rblock);
        end else begin
            compare_word("icache rword", model_word(i_addr), rword);
        end
        i_busy = 1'b0;
    endtask

    // sampled at the falling edge where the response pulse is stable
    task automatic collect_response();
        resp_e got;
        resp_e exp;
        @(negedge clk);
        while (response == RESP_NONE) begin
            @(negedge clk);
        end
        got = response;
        if (exp_order.size() == 0) begin
            $display("error: %s got a response with no request outstanding", test_name);
            stop_with_failure();
        end else begin
            exp = exp_order.pop_front();
            compare_resp(exp, got);
            if (got == RESP_DCACHE) begin
                check_dcache_result();
            end else begin
                check_icache_result();
            end
        end
    endtask

    initial begin
        rstn          = 1'b0;
        icache_req    = ICACHE_REQ_NONE;
        icache_addr   = '0;
        dcache_req    = DCACHE_REQ_NONE;
        dcache_addr   = '0;
        dcache_wword  = '0;
        dcache_wstrb  = '0;
        dcache_wblock = '0;
        d_busy        = 1'b0;
        i_busy        = 1'b0;
        issued        = 0;
        answered      = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_name = "reset";
        @(negedge clk);
        compare_resp(RESP_NONE, response);

        test_name = "store_word_strobe";
        send_requests(DCACHE_REQ_STORE_WORD, 32'h40, 32'h1122_3344, 4'hF, '0, ICACHE_REQ_NONE, '0);
        collect_response();
        send_requests(DCACHE_REQ_STORE_WORD, 32'h41, 32'hAABB_CCDD, 4'b0101, '0,
                      ICACHE_REQ_NONE, '0);
        collect_response();
        send_requests(DCACHE_REQ_LOAD_WORD, 32'h42, '0, '0, '0, ICACHE_REQ_NONE, '0);
        collect_response();
        // bytes 0 and 2 replaced
        compare_word("merged word", 32'h11BB_33DD, rword);

        test_name = "block_store_load";
        blk = rand_block();
        send_requests(DCACHE_REQ_STORE_BLOCK, 32'h1A4, '0, '0, blk, ICACHE_REQ_NONE, '0);
        collect_response();
        send_requests(DCACHE_REQ_LOAD_BLOCK, 32'h1A8, '0, '0, '0, ICACHE_REQ_NONE, '0);
        collect_response();
        compare_block("stored block", blk, rblock);

        test_name = "icache_loads";
        send_requests(DCACHE_REQ_NONE, '0, '0, '0, '0, ICACHE_REQ_BLOCK, 32'h1AC);
        collect_response();
        send_requests(DCACHE_REQ_NONE, '0, '0, '0, '0, ICACHE_REQ_WORD, 32'h1A4);
        collect_response();
        compare_word("block word 1", blk[WORD_BITS +: WORD_BITS], rword);

        test_name = "same_cycle_priority";
        send_requests(DCACHE_REQ_STORE_WORD, 32'h1A0, 32'h5A5A_0F0F, 4'hF, '0,
                      ICACHE_REQ_WORD, 32'h1A0);
        collect_response();
        collect_response();
        // icache load ran after the dcache store
        compare_word("icache after store", 32'h5A5A_0F0F, rword);

        test_name = "random_mixed";
        remaining = NUM_RANDOM;
        while (remaining > 0 || d_busy || i_busy) begin
            dk = DCACHE_REQ_NONE;
            ik = ICACHE_REQ_NONE;
            if (remaining > 0 && !d_busy && ($random(seed) & 1)) begin
                dk = rand_dcache_kind();
                remaining--;
            end
            if (remaining > 0 && !i_busy && ($random(seed) & 1)) begin
                ik = rand_icache_kind();
                remaining--;
            end
            if (dk == DCACHE_REQ_NONE && ik == ICACHE_REQ_NONE && !d_busy && !i_busy) begin
                dk = rand_dcache_kind();
                remaining--;
            end
            if (dk != DCACHE_REQ_NONE || ik != ICACHE_REQ_NONE) begin
                send_requests(dk, rand_addr(), $random(seed), strb_t'($random(seed)),
                              rand_block(), ik, rand_addr());
            end
            collect_response();
        end

        // late stray responses still reach the count
        repeat (60) @(posedge clk);

        if (answered == issued) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("error: %0d requests got %0d response cycles", issued, answered);
            stop_with_failure();
        end
    end

endmodule

//--- rtl/apb_burst_master.sv
`timescale 1ns/1ps

module apb_burst_master
    import cache_mem_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  bus_req_t bus_req,
    output bus_rsp_t bus_rsp,
    output apb_req_t apb_out,
    input  apb_rsp_t apb_in
);

    localparam int BEAT_W   = $clog2(BLOCK_WORDS);
    localparam int WORD_W   = $bits(word_t);
    localparam int BLOCK_W  = $bits(block_t);

    typedef enum logic [1:0] {
        M_IDLE,
        M_SETUP,
        M_ACCESS,
        M_DONE
    } mst_state_e;

    mst_state_e        state;
    bus_op_e           op_q;
    logic [BEAT_W-1:0] beat_q;
    logic              ready_q;

    addr_t             base_q;
    word_t             wword_q;
    strb_t             wstrb_q;
    block_t            wblock_q;
    word_t             rword_q;
    block_t            rblock_q;

    logic              accept;
    logic              beat_done;
    logic              is_block;
    logic              is_store;
    logic              last_beat;

    assign accept    = (state == M_IDLE) && (bus_req.op != BUS_NONE);
    assign beat_done = (state == M_ACCESS) && apb_in.pready;
    assign is_block  = (op_q == BUS_LOAD_BLOCK) || (op_q == BUS_STORE_BLOCK);
    assign is_store  = (op_q == BUS_STORE_WORD) || (op_q == BUS_STORE_BLOCK);
    // a word op is a single beat
    assign last_beat = !is_block || (beat_q == BEAT_W'(BLOCK_WORDS - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= M_IDLE;
            op_q    <= BUS_NONE;
            beat_q  <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (accept) begin
                        state   <= M_SETUP;
                        op_q    <= bus_req.op;
                        beat_q  <= '0;
                        ready_q <= 1'b1;
                    end
                end
                M_SETUP: begin
                    state <= M_ACCESS;
                end
                M_ACCESS: begin
                    if (apb_in.pready) begin
                        if (last_beat) begin
                            state <= M_DONE;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                            state  <= M_SETUP;
                        end
                    end
                end
                default: begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

    // aligned base address and write data
    always_ff @(posedge clk) begin
        if (accept) begin
            if ((bus_req.op == BUS_LOAD_BLOCK) || (bus_req.op == BUS_STORE_BLOCK)) begin
                base_q <= bus_req.addr & ~addr_t'(4 * BLOCK_WORDS - 1);
            end else begin
                base_q <= bus_req.addr & ~addr_t'(3);
            end
            wword_q  <= bus_req.wword;
            wstrb_q  <= bus_req.wstrb;
            wblock_q <= bus_req.wblock;
        end
    end

    // beats shift in from the top, so word 0 ends up low
    always_ff @(posedge clk) begin
        if (beat_done) begin
            rword_q  <= apb_in.prdata;
            rblock_q <= {apb_in.prdata, rblock_q[BLOCK_W-1:WORD_W]};
        end
    end

    assign apb_out.psel    = (state == M_SETUP) || (state == M_ACCESS);
    assign apb_out.penable = (state == M_ACCESS);
    assign apb_out.pwrite  = is_store;
    assign apb_out.paddr   = base_q + addr_t'({beat_q, 2'b00});
    assign apb_out.pwdata  = is_block ? wblock_q[beat_q*WORD_W +: WORD_W] : wword_q;
    // no strobes on reads
    assign apb_out.pstrb   = !is_store ? '0 : (is_block ? '1 : wstrb_q);

    assign bus_rsp.ready  = ready_q;
    assign bus_rsp.finish = (state == M_DONE);
    assign bus_rsp.rword  = rword_q;
    assign bus_rsp.rblock = rblock_q;

endmodule

//--- rtl/cache_mem_pkg.sv
package cache_mem_pkg;

    // words per cache block
    localparam int BLOCK_WORDS = 4;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    // word 0 sits in the low bits
    typedef logic [BLOCK_WORDS*$bits(word_t)-1:0] block_t;

    typedef enum logic [1:0] {
        ICACHE_REQ_NONE,
        ICACHE_REQ_WORD,
        ICACHE_REQ_BLOCK
    } icache_req_e;

    typedef enum logic [2:0] {
        DCACHE_REQ_NONE,
        DCACHE_REQ_LOAD_WORD,
        DCACHE_REQ_LOAD_BLOCK,
        DCACHE_REQ_STORE_WORD,
        DCACHE_REQ_STORE_BLOCK
    } dcache_req_e;

    typedef enum logic [2:0] {
        BUS_NONE,
        BUS_LOAD_WORD,
        BUS_LOAD_BLOCK,
        BUS_STORE_WORD,
        BUS_STORE_BLOCK
    } bus_op_e;

    typedef enum logic [1:0] {
        RESP_NONE,
        RESP_ICACHE,
        RESP_DCACHE
    } resp_e;

    // arbiter to bus master
    typedef struct packed {
        bus_op_e op;
        addr_t   addr;
        word_t   wword;
        strb_t   wstrb;
        block_t  wblock;
    } bus_req_t;

    // bus master back to arbiter
    typedef struct packed {
        logic   ready;
        logic   finish;
        word_t  rword;
        block_t rblock;
    } bus_rsp_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
        strb_t pstrb;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
    } apb_rsp_t;

endpackage

//--- rtl/cache_mem_top.sv
`timescale 1ns/1ps

module cache_mem_top
    import cache_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  icache_req_e icache_req,
    input  addr_t       icache_addr,
    input  dcache_req_e dcache_req,
    input  addr_t       dcache_addr,
    input  word_t       dcache_wword,
    input  strb_t       dcache_wstrb,
    input  block_t      dcache_wblock,
    output resp_e       response,
    output word_t       rword,
    output block_t      rblock,
    output apb_req_t    apb_out,
    input  apb_rsp_t    apb_in
);

    // internal request/finish handshake
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;

    mem_req_arbiter u_arbiter (
        .clk           (clk),
        .rstn          (rstn),
        .icache_req    (icache_req),
        .icache_addr   (icache_addr),
        .dcache_req    (dcache_req),
        .dcache_addr   (dcache_addr),
        .dcache_wword  (dcache_wword),
        .dcache_wstrb  (dcache_wstrb),
        .dcache_wblock (dcache_wblock),
        .response      (response),
        .rword         (rword),
        .rblock        (rblock),
        .bus_req       (bus_req),
        .bus_rsp       (bus_rsp)
    );

    apb_burst_master u_master (
        .clk     (clk),
        .rstn    (rstn),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .apb_out (apb_out),
        .apb_in  (apb_in)
    );

endmodule

//--- rtl/mem_req_arbiter.sv
`timescale 1ns/1ps

module mem_req_arbiter
    import cache_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  icache_req_e icache_req,
    input  addr_t       icache_addr,
    input  dcache_req_e dcache_req,
    input  addr_t       dcache_addr,
    input  word_t       dcache_wword,
    input  strb_t       dcache_wstrb,
    input  block_t      dcache_wblock,
    output resp_e       response,
    output word_t       rword,
    output block_t      rblock,
    output bus_req_t    bus_req,
    input  bus_rsp_t    bus_rsp
);

    typedef enum logic [1:0] {
        ARB_WAIT,
        ARB_REQ,
        ARB_WAIT_FINISH,
        ARB_FINISH
    } arb_state_e;

    arb_state_e  cs;
    arb_state_e  ns;

    // one captured request per side
    icache_req_e ireq_q;
    addr_t       iaddr_q;
    dcache_req_e dreq_q;
    addr_t       daddr_q;
    word_t       dwword_q;
    strb_t       dwstrb_q;
    block_t      dwblock_q;

    logic        pick_dcache;
    bus_op_e     pick_op;
    logic        sel_dcache;
    logic        grant;
    logic        done;
    bus_op_e     op_q;
    addr_t       addr_q;

    assign grant = (cs == ARB_WAIT) && (ns == ARB_REQ);
    assign done  = (ns == ARB_FINISH);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ireq_q <= ICACHE_REQ_NONE;
        end else if (done && !sel_dcache) begin
            ireq_q <= ICACHE_REQ_NONE;
        end else if (icache_req != ICACHE_REQ_NONE) begin
            ireq_q <= icache_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dreq_q <= DCACHE_REQ_NONE;
        end else if (done && sel_dcache) begin
            dreq_q <= DCACHE_REQ_NONE;
        end else if (dcache_req != DCACHE_REQ_NONE) begin
            dreq_q <= dcache_req;
        end
    end

    always_ff @(posedge clk) begin
        if (icache_req != ICACHE_REQ_NONE) begin
            iaddr_q <= icache_addr;
        end
        if (dcache_req != DCACHE_REQ_NONE) begin
            daddr_q   <= dcache_addr;
            dwword_q  <= dcache_wword;
            dwstrb_q  <= dcache_wstrb;
            dwblock_q <= dcache_wblock;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cs <= ARB_WAIT;
        end else begin
            cs <= ns;
        end
    end

    // dcache wins over icache when both are pending
    always_comb begin
        ns          = cs;
        pick_dcache = 1'b0;
        pick_op     = BUS_NONE;
        case (cs)
            ARB_WAIT: begin
                if (dreq_q != DCACHE_REQ_NONE) begin
                    ns          = ARB_REQ;
                    pick_dcache = 1'b1;
                    case (dreq_q)
                        DCACHE_REQ_LOAD_WORD:   pick_op = BUS_LOAD_WORD;
                        DCACHE_REQ_LOAD_BLOCK:  pick_op = BUS_LOAD_BLOCK;
                        DCACHE_REQ_STORE_WORD:  pick_op = BUS_STORE_WORD;
                        default:                pick_op = BUS_STORE_BLOCK;
                    endcase
                end else if (ireq_q != ICACHE_REQ_NONE) begin
                    ns      = ARB_REQ;
                    pick_op = (ireq_q == ICACHE_REQ_BLOCK) ? BUS_LOAD_BLOCK : BUS_LOAD_WORD;
                end
            end
            ARB_REQ: begin
                if (bus_rsp.ready) begin
                    ns = ARB_WAIT_FINISH;
                end
            end
            ARB_WAIT_FINISH: begin
                if (bus_rsp.finish) begin
                    ns = ARB_FINISH;
                end
            end
            default: begin
                ns = ARB_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sel_dcache <= 1'b0;
            op_q       <= BUS_NONE;
        end else if (grant) begin
            sel_dcache <= pick_dcache;
            op_q       <= pick_op;
        end else if ((cs == ARB_REQ) && bus_rsp.ready) begin
            op_q <= BUS_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            addr_q <= pick_dcache ? daddr_q : iaddr_q;
        end
    end

    // write data stays in the dcache capture until its response
    assign bus_req = '{
        op:     op_q,
        addr:   addr_q,
        wword:  dwword_q,
        wstrb:  dwstrb_q,
        wblock: dwblock_q
    };

    always_ff @(posedge clk) begin
        if (!rstn) begin
            response <= RESP_NONE;
        end else if (done) begin
            response <= sel_dcache ? RESP_DCACHE : RESP_ICACHE;
        end else begin
            response <= RESP_NONE;
        end
    end

    // load data held until the next completion
    always_ff @(posedge clk) begin
        if (done) begin
            rword  <= bus_rsp.rword;
            rblock <= bus_rsp.rblock;
        end
    end

endmodule

//--- tb.f
rtl/cache_mem_pkg.sv
rtl/mem_req_arbiter.sv
rtl/apb_burst_master.sv
rtl/cache_mem_top.sv
dv/apb_mem_model.sv
dv/tb_cache_mem.sv
